// File: fetch_pkg.sv
package fetch_pkg;

  // Control-transfer kind stored with each BTB entry
  typedef enum logic [1:0] {
    br_jump   = 2'd0,
    br_call   = 2'd1,
    br_return = 2'd2
  } br_kind_e;

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  // Width of the BTB saturating counters
  localparam int CTR_W = 2;

endpackage

// File: fetch_pred_if.sv
`timescale 1ns/10ps

interface fetch_pred_if
  import fetch_pkg::*;
#(
  parameter int XLEN = 32
) ();

  // BTB lookup result for the current PC
  logic            btb_hit;
  logic            btb_pred_taken;
  logic [XLEN-1:0] btb_tgt;
  br_kind_e        btb_kind;

  // Top of the return stack
  logic            ras_valid;
  logic [XLEN-1:0] ras_tgt;

  modport btb_src (
    output btb_hit, btb_pred_taken, btb_tgt, btb_kind
  );

  modport ras_src (
    output ras_valid, ras_tgt
  );

  // PC generator and fetch stage only read
  modport sink (
    input btb_hit, btb_pred_taken, btb_tgt, btb_kind, ras_valid, ras_tgt
  );

endinterface

// File: fetch_pc_gen.sv
`timescale 1ns/10ps

module fetch_pc_gen
  import fetch_pkg::*;
#(
  parameter int              XLEN     = 32,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            advance,
  input  logic            redirect_valid,
  input  logic [XLEN-1:0] redirect_pc,
  fetch_pred_if.sink      pred,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] pc_plus4
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  logic            take_ras;
  logic            take_btb;

  // Single sequential adder, shared with RAS push and the stage
  assign pc_plus4 = pc_q + XLEN'(4);
  assign pc       = pc_q;

  // Return needs a live RAS entry, else it falls through
  assign take_ras = pred.btb_hit && (pred.btb_kind == br_return) && pred.ras_valid;
  // Jumps and calls follow the counter
  assign take_btb = pred.btb_hit && pred.btb_pred_taken && (pred.btb_kind != br_return);

  // Next-PC select, redirect first
  always_comb begin
    if (redirect_valid) begin
      pc_next = redirect_pc;
    end else if (!advance) begin
      // Stalled by the consumer
      pc_next = pc_q;
    end else if (take_ras) begin
      pc_next = pred.ras_tgt;
    end else if (take_btb) begin
      pc_next = pred.btb_tgt;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

endmodule

// File: fetch_btb.sv
`timescale 1ns/10ps

module fetch_btb
  import fetch_pkg::*;
#(
  parameter int XLEN        = 32,
  parameter int BTB_ENTRIES = 16
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [XLEN-1:0] pc,
  input  logic            upd_valid,
  input  logic [XLEN-1:0] upd_pc,
  input  logic [XLEN-1:0] upd_tgt,
  input  logic            upd_taken,
  input  br_kind_e        upd_kind,
  fetch_pred_if.btb_src   pred
);

  // Index sits just above the byte offset, tag takes the rest
  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - IDX_W - 2;

  localparam logic [CTR_W-1:0] CTR_MAX  = '1;
  // Weakly taken on install
  localparam logic [CTR_W-1:0] CTR_INIT = {1'b1, {(CTR_W-1){1'b0}}};

  // Entry storage
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q  [BTB_ENTRIES];
  logic [XLEN-1:0]        tgt_q  [BTB_ENTRIES];
  br_kind_e               kind_q [BTB_ENTRIES];
  logic [CTR_W-1:0]       ctr_q  [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic             rd_hit;

  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_hit;
  logic             wr_train;
  logic             wr_install;
  logic [CTR_W-1:0] ctr_cur;
  logic [CTR_W-1:0] ctr_next;

  // Lookup side, purely combinational
  assign rd_idx = pc[IDX_W+1:2];
  assign rd_tag = pc[XLEN-1:IDX_W+2];
  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  // Miss presents zeros
  assign pred.btb_hit        = rd_hit;
  assign pred.btb_pred_taken = rd_hit && ctr_q[rd_idx][CTR_W-1];
  assign pred.btb_tgt        = rd_hit ? tgt_q[rd_idx] : '0;
  assign pred.btb_kind       = rd_hit ? kind_q[rd_idx] : br_jump;

  // Update side from branch resolution
  assign wr_idx     = upd_pc[IDX_W+1:2];
  assign wr_tag     = upd_pc[XLEN-1:IDX_W+2];
  assign wr_hit     = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);
  assign wr_train   = upd_valid && wr_hit;
  // Not-taken misses are not allocated
  assign wr_install = upd_valid && !wr_hit && upd_taken;
  assign ctr_cur    = ctr_q[wr_idx];

  // Saturating 2-bit counter step
  always_comb begin
    if (wr_install) begin
      ctr_next = CTR_INIT;
    end else if (upd_taken) begin
      ctr_next = (ctr_cur == CTR_MAX) ? ctr_cur : ctr_cur + 1'b1;
    end else begin
      ctr_next = (ctr_cur == '0) ? ctr_cur : ctr_cur - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (wr_install) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Payload arrays
  always_ff @(posedge clk) begin
    if (wr_train || wr_install) begin
      tag_q[wr_idx]  <= wr_tag;
      tgt_q[wr_idx]  <= upd_tgt;
      kind_q[wr_idx] <= upd_kind;
      ctr_q[wr_idx]  <= ctr_next;
    end
  end

endmodule

// File: fetch_ras.sv
`timescale 1ns/10ps

module fetch_ras #(
  parameter int XLEN      = 32,
  parameter int RAS_DEPTH = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            push,
  input  logic            pop,
  input  logic [XLEN-1:0] push_addr,
  fetch_pred_if.ras_src   pred
);

  localparam int PTR_W = $clog2(RAS_DEPTH);
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(RAS_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(RAS_DEPTH);

  logic [XLEN-1:0]  stack_q [RAS_DEPTH];
  logic [PTR_W-1:0] tos_q;
  logic [CNT_W-1:0] cnt_q;
  logic [PTR_W-1:0] tos_up;
  logic [PTR_W-1:0] tos_dn;
  logic             do_pop;

  // Circular neighbours of the top pointer
  assign tos_up = (tos_q == PTR_LAST) ? '0 : tos_q + 1'b1;
  assign tos_dn = (tos_q == '0) ? PTR_LAST : tos_q - 1'b1;

  // Empty stack ignores pops
  assign do_pop = pop && (cnt_q != '0);

  assign pred.ras_valid = (cnt_q != '0);
  assign pred.ras_tgt   = pred.ras_valid ? stack_q[tos_q] : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tos_q <= '0;
      cnt_q <= '0;
    end else if (push && do_pop) begin
      // Replace top, depth unchanged
      tos_q <= tos_q;
    end else if (push) begin
      tos_q <= tos_up;
      // Full stack drops the oldest entry
      cnt_q <= (cnt_q == CNT_FULL) ? cnt_q : cnt_q + 1'b1;
    end else if (do_pop) begin
      tos_q <= tos_dn;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && do_pop) begin
      stack_q[tos_q] <= push_addr;
    end else if (push) begin
      stack_q[tos_up] <= push_addr;
    end
  end

endmodule

// File: fetch_stage_sram.sv
`timescale 1ns/10ps

module fetch_stage_sram
  import fetch_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int PIPELINED = 1
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] pc_plus4,
  input  logic            flush,
  input  logic            out_ready,
  fetch_pred_if.sink      pred,
  output logic            imem_arvalid,
  output logic [31:0]     imem_araddr,
  input  logic [31:0]     imem_rdata,
  output logic            out_valid,
  output logic [31:0]     out_instr,
  output logic [XLEN-1:0] out_pc,
  output logic [XLEN-1:0] out_pc_plus4,
  output logic            out_btb_hit,
  output logic            out_btb_pred_taken,
  output logic [XLEN-1:0] out_btb_tgt,
  output br_kind_e        out_btb_kind,
  output logic            out_ras_valid,
  output logic [XLEN-1:0] out_ras_tgt,
  output logic            advance
);

  // Zero-latency SRAM, read every cycle
  assign imem_arvalid = 1'b1;
  assign imem_araddr  = pc[31:0];

  if (PIPELINED != 0) begin : g_registered
    logic [31:0] instr_q;
    logic        valid_q;

    // Register loads whenever the consumer can take a word
    assign advance = out_ready;

    // Flush and reset leave a bubble
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        instr_q <= I_NOP;
        valid_q <= 1'b0;
      end else if (flush) begin
        instr_q <= I_NOP;
        valid_q <= 1'b0;
      end else if (out_ready) begin
        instr_q <= imem_rdata;
        valid_q <= 1'b1;
      end
    end

    // PC and prediction travel with the instruction
    always_ff @(posedge clk) begin
      if (out_ready) begin
        out_pc             <= pc;
        out_pc_plus4       <= pc_plus4;
        out_btb_hit        <= pred.btb_hit;
        out_btb_pred_taken <= pred.btb_pred_taken;
        out_btb_tgt        <= pred.btb_tgt;
        out_btb_kind       <= pred.btb_kind;
        out_ras_valid      <= pred.ras_valid;
        out_ras_tgt        <= pred.ras_tgt;
      end
    end

    assign out_instr = instr_q;
    assign out_valid = valid_q;
  end else begin : g_passthrough
    logic run_q;

    // Goes high on the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        run_q <= 1'b0;
      end else begin
        run_q <= 1'b1;
      end
    end

    // Wrong-path word is dropped during a redirect
    assign out_valid = run_q && !flush;
    assign advance   = out_ready && out_valid;

    assign out_instr          = imem_rdata;
    assign out_pc             = pc;
    assign out_pc_plus4       = pc_plus4;
    assign out_btb_hit        = pred.btb_hit;
    assign out_btb_pred_taken = pred.btb_pred_taken;
    assign out_btb_tgt        = pred.btb_tgt;
    assign out_btb_kind       = pred.btb_kind;
    assign out_ras_valid      = pred.ras_valid;
    assign out_ras_tgt        = pred.ras_tgt;
  end

endmodule

// File: fetch_top.sv
`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
#(
  parameter int              XLEN        = 32,
  parameter int              PIPELINED   = 1,
  parameter logic [XLEN-1:0] RESET_PC    = 'h100,
  parameter int              BTB_ENTRIES = 16,
  parameter int              RAS_DEPTH   = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  // Instruction SRAM
  output logic            imem_arvalid,
  output logic [31:0]     imem_araddr,
  input  logic [31:0]     imem_rdata,
  // Consumer side
  output logic            out_valid,
  input  logic            out_ready,
  output logic [31:0]     out_instr,
  output logic [XLEN-1:0] out_pc,
  output logic [XLEN-1:0] out_pc_plus4,
  output logic            out_btb_hit,
  output logic            out_btb_pred_taken,
  output logic [XLEN-1:0] out_btb_tgt,
  output br_kind_e        out_btb_kind,
  output logic            out_ras_valid,
  output logic [XLEN-1:0] out_ras_tgt,
  // Redirect from branch resolution
  input  logic            redirect_valid,
  input  logic [XLEN-1:0] redirect_pc,
  // BTB training
  input  logic            upd_valid,
  input  logic [XLEN-1:0] upd_pc,
  input  logic [XLEN-1:0] upd_tgt,
  input  logic            upd_taken,
  input  br_kind_e        upd_kind
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_plus4;
  logic            advance;
  logic            step;
  logic            ras_push;
  logic            ras_pop;

  fetch_pred_if #(.XLEN(XLEN)) u_pred ();

  // Speculative RAS moves only on a real, non-redirected step
  assign step     = advance && !redirect_valid;
  assign ras_push = step && u_pred.btb_hit && u_pred.btb_pred_taken
                    && (u_pred.btb_kind == br_call);
  assign ras_pop  = step && u_pred.btb_hit && u_pred.ras_valid
                    && (u_pred.btb_kind == br_return);

  fetch_pc_gen #(
    .XLEN     (XLEN),
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk            (clk),
    .arst_n         (arst_n),
    .advance        (advance),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pred           (u_pred.sink),
    .pc             (pc),
    .pc_plus4       (pc_plus4)
  );

  fetch_btb #(
    .XLEN        (XLEN),
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_btb (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc        (pc),
    .upd_valid (upd_valid),
    .upd_pc    (upd_pc),
    .upd_tgt   (upd_tgt),
    .upd_taken (upd_taken),
    .upd_kind  (upd_kind),
    .pred      (u_pred.btb_src)
  );

  // Return address is the call's fall-through PC
  fetch_ras #(
    .XLEN      (XLEN),
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (pc_plus4),
    .pred      (u_pred.ras_src)
  );

  fetch_stage_sram #(
    .XLEN      (XLEN),
    .PIPELINED (PIPELINED)
  ) u_stage (
    .clk                (clk),
    .arst_n             (arst_n),
    .pc                 (pc),
    .pc_plus4           (pc_plus4),
    .flush              (redirect_valid),
    .out_ready          (out_ready),
    .pred               (u_pred.sink),
    .imem_arvalid       (imem_arvalid),
    .imem_araddr        (imem_araddr),
    .imem_rdata         (imem_rdata),
    .out_valid          (out_valid),
    .out_instr          (out_instr),
    .out_pc             (out_pc),
    .out_pc_plus4       (out_pc_plus4),
    .out_btb_hit        (out_btb_hit),
    .out_btb_pred_taken (out_btb_pred_taken),
    .out_btb_tgt        (out_btb_tgt),
    .out_btb_kind       (out_btb_kind),
    .out_ras_valid      (out_ras_valid),
    .out_ras_tgt        (out_ras_tgt),
    .advance            (advance)
  );

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/10ps

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int          XLEN     = 32;
  localparam logic [31:0] RESET_PC = 32'h0000_0100;
  // Scrambles the image so a stale or misrouted word never matches
  localparam logic [31:0] IMG_KEY  = 32'h5A3C_9613;
  // Roughly five times the length of all tests together
  localparam int          TIMEOUT  = 3000;

  logic            clk;
  logic            arst_n;
  logic            imem_arvalid;
  logic [31:0]     imem_araddr;
  logic [31:0]     imem_rdata;
  logic            out_valid;
  logic            out_ready;
  logic [31:0]     out_instr;
  logic [XLEN-1:0] out_pc;
  logic [XLEN-1:0] out_pc_plus4;
  logic            out_btb_hit;
  logic            out_btb_pred_taken;
  logic [XLEN-1:0] out_btb_tgt;
  br_kind_e        out_btb_kind;
  logic            out_ras_valid;
  logic [XLEN-1:0] out_ras_tgt;
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;
  logic            upd_valid;
  logic [XLEN-1:0] upd_pc;
  logic [XLEN-1:0] upd_tgt;
  logic            upd_taken;
  br_kind_e        upd_kind;

  int          err_count    = 0;
  int          err_mark     = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycles       = 0;
  logic        fire;
  logic [31:0] exp_pc;
  // Field probe on one chosen PC
  logic [31:0] probe_pc;
  logic        probe_btb;
  logic        probe_taken;
  logic [31:0] probe_tgt;
  br_kind_e    probe_kind;
  logic        probe_ras;
  logic [31:0] probe_ras_tgt;

  fetch_top #(
    .XLEN        (XLEN),
    .PIPELINED   (1),
    .RESET_PC    (RESET_PC),
    .BTB_ENTRIES (16),
    .RAS_DEPTH   (4)
  ) u_dut (
    .clk (clk), .arst_n (arst_n),
    .imem_arvalid (imem_arvalid), .imem_araddr (imem_araddr), .imem_rdata (imem_rdata),
    .out_valid (out_valid), .out_ready (out_ready), .out_instr (out_instr),
    .out_pc (out_pc), .out_pc_plus4 (out_pc_plus4),
    .out_btb_hit (out_btb_hit), .out_btb_pred_taken (out_btb_pred_taken),
    .out_btb_tgt (out_btb_tgt), .out_btb_kind (out_btb_kind),
    .out_ras_valid (out_ras_valid), .out_ras_tgt (out_ras_tgt),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .upd_valid (upd_valid), .upd_pc (upd_pc), .upd_tgt (upd_tgt),
    .upd_taken (upd_taken), .upd_kind (upd_kind)
  );

  // Word address rotated with the byte offset, then scrambled
  function automatic logic [31:0] image_word(input logic [31:0] addr);
    return {addr[1:0], addr[31:2]} ^ IMG_KEY;
  endfunction

  // Successor of a fired PC, from the prediction fields it carried
  function automatic logic [31:0] predict_next(
    input logic [31:0] pc, input logic hit, input logic taken,
    input logic [31:0] tgt, input br_kind_e kind,
    input logic ras_v, input logic [31:0] ras_tgt
  );
    if (hit && kind == br_return && ras_v) begin
      return ras_tgt;
    end
    if (hit && taken && kind != br_return) begin
      return tgt;
    end
    return pc + 32'd4;
  endfunction

  // Zero-latency instruction SRAM
  assign imem_rdata = image_word(imem_araddr);
  assign fire       = out_valid && out_ready;

  // Expected PC of the next fire
  always @(posedge clk) begin
    if (!arst_n) begin
      exp_pc <= RESET_PC;
    end else if (redirect_valid) begin
      exp_pc <= redirect_pc;
    end else if (fire) begin
      exp_pc <= predict_next(out_pc, out_btb_hit, out_btb_pred_taken, out_btb_tgt,
                             out_btb_kind, out_ras_valid, out_ras_tgt);
    end
  end

  task automatic note_error(input string msg);
    err_count++;
    $display("%s", msg);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    note_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  a_reset_quiet: assert property (@(posedge clk)
      (!arst_n || $rose(arst_n)) |-> !out_valid)
    else report_mismatch("out_valid", $sampled(out_valid), 32'h0);

  // SRAM read request is always on
  a_arvalid: assert property (@(posedge clk) disable iff (!arst_n)
      imem_arvalid)
    else report_mismatch("imem_arvalid", $sampled(imem_arvalid), 32'h1);

  a_instr: assert property (@(posedge clk) disable iff (!arst_n)
      fire |-> out_instr == image_word(out_pc))
    else report_mismatch("out_instr", $sampled(out_instr), image_word($sampled(out_pc)));

  a_pc_plus4: assert property (@(posedge clk) disable iff (!arst_n)
      fire |-> out_pc_plus4 == out_pc + 32'd4)
    else report_mismatch("out_pc_plus4", $sampled(out_pc_plus4), $sampled(out_pc) + 32'd4);

  a_next_pc: assert property (@(posedge clk) disable iff (!arst_n)
      fire |-> out_pc == exp_pc)
    else report_mismatch("out_pc", $sampled(out_pc), $sampled(exp_pc));

  // Held word under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready && !redirect_valid |=> $stable({out_valid, out_instr,
        out_pc, out_pc_plus4, out_btb_hit, out_btb_pred_taken, out_btb_tgt,
        out_btb_kind, out_ras_valid, out_ras_tgt}))
    else note_error($sformatf("Output word changed while stalled, now at pc 0x%h",
                              $sampled(out_pc)));

  a_flush_valid: assert property (@(posedge clk) disable iff (!arst_n)
      redirect_valid |=> !out_valid)
    else report_mismatch("out_valid", $sampled(out_valid), 32'h0);

  a_flush_nop: assert property (@(posedge clk) disable iff (!arst_n)
      redirect_valid |=> out_instr == I_NOP)
    else report_mismatch("out_instr", $sampled(out_instr), I_NOP);

  a_probe_btb: assert property (@(posedge clk) disable iff (!arst_n)
      fire && probe_btb && out_pc == probe_pc |->
        out_btb_hit && out_btb_pred_taken == probe_taken && out_btb_tgt == probe_tgt)
    else note_error($sformatf("Mismatch %s: got 0x%h/0x%h/0x%h, expected 0x1/0x%h/0x%h",
      "out_btb_hit/out_btb_pred_taken/out_btb_tgt",
      $sampled(out_btb_hit), $sampled(out_btb_pred_taken), $sampled(out_btb_tgt),
      $sampled(probe_taken), $sampled(probe_tgt)));

  a_probe_kind: assert property (@(posedge clk) disable iff (!arst_n)
      fire && probe_btb && out_pc == probe_pc |-> out_btb_kind == probe_kind)
    else report_mismatch("out_btb_kind", $sampled(out_btb_kind), $sampled(probe_kind));

  a_probe_ras: assert property (@(posedge clk) disable iff (!arst_n)
      fire && probe_ras && out_pc == probe_pc |-> out_ras_valid && out_ras_tgt == probe_ras_tgt)
    else note_error($sformatf(
      "Mismatch out_ras_valid/out_ras_tgt: got 0x%h/0x%h, expected 0x1/0x%h",
      $sampled(out_ras_valid), $sampled(out_ras_tgt), $sampled(probe_ras_tgt)));

  task automatic wait_fires(input int n);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      if (fire) got++;
    end
  endtask

  task automatic wait_fire_at(input logic [31:0] pc);
    do begin
      @(posedge clk);
    end while (!(fire && out_pc == pc));
  endtask

  task automatic pulse_redirect(input logic [31:0] target);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  // One resolved branch into the BTB
  task automatic train(input logic [31:0] pc, input logic [31:0] tgt, input logic taken,
                       input br_kind_e kind);
    @(posedge clk);
    upd_valid <= 1'b1;
    upd_pc    <= pc;
    upd_tgt   <= tgt;
    upd_taken <= taken;
    upd_kind  <= kind;
    @(posedge clk);
    upd_valid <= 1'b0;
  endtask

  // Late assertion results land before the verdict
  task automatic close_test(input string name);
    repeat (2) @(posedge clk);
    tests_run++;
    if (err_count == err_mark) begin
      $display("Test %-20s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-20s FAILED with %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  task automatic random_backpressure();
    int got;
    got = 0;
    while (got < 80) begin
      @(posedge clk);
      if (fire) got++;
      out_ready <= ($urandom % 3) != 0;
    end
    out_ready <= 1'b1;
  endtask

  task automatic redirect_flush();
    pulse_redirect(32'h400);
    wait_fire_at(32'h400);
    wait_fires(4);
    // Redirect while the consumer stalls
    @(posedge clk);
    out_ready <= 1'b0;
    pulse_redirect(32'h480);
    @(posedge clk);
    out_ready <= 1'b1;
    wait_fire_at(32'h480);
  endtask

  task automatic btb_jump();
    train(32'h200, 32'h300, 1'b1, br_jump);
    probe_pc    = 32'h200;
    probe_tgt   = 32'h300;
    probe_kind  = br_jump;
    probe_taken = 1'b1;
    probe_btb   = 1'b1;
    pulse_redirect(32'h1F0);
    wait_fire_at(32'h200);
    wait_fires(2);
    // Two not-taken outcomes drain the counter to zero
    train(32'h200, 32'h300, 1'b0, br_jump);
    train(32'h200, 32'h300, 1'b0, br_jump);
    probe_taken = 1'b0;
    pulse_redirect(32'h1F0);
    wait_fire_at(32'h200);
    wait_fires(2);
    probe_btb = 1'b0;
  endtask

  task automatic call_return();
    train(32'h600, 32'h700, 1'b1, br_call);
    train(32'h710, 32'h0, 1'b1, br_return);
    probe_pc      = 32'h710;
    probe_ras_tgt = 32'h604;
    probe_ras     = 1'b1;
    pulse_redirect(32'h5F8);
    wait_fire_at(32'h710);
    wait_fire_at(32'h604);
    probe_ras = 1'b0;
  endtask

  // Top of stack seen at one return, then that return fires
  task automatic expect_return(input logic [31:0] ret_pc, input logic [31:0] ret_tgt);
    probe_pc      = ret_pc;
    probe_ras_tgt = ret_tgt;
    probe_ras     = 1'b1;
    wait_fire_at(ret_pc);
  endtask

  // Five call levels, each on its own BTB index
  task automatic nested_calls();
    train(32'h800, 32'h900, 1'b1, br_call);
    train(32'h904, 32'hA00, 1'b1, br_call);
    train(32'hA0C, 32'hB00, 1'b1, br_call);
    train(32'hB14, 32'hC00, 1'b1, br_call);
    train(32'hC1C, 32'hD00, 1'b1, br_call);
    train(32'hD24, 32'h0, 1'b1, br_return);
    train(32'hC20, 32'h0, 1'b1, br_return);
    train(32'hB18, 32'h0, 1'b1, br_return);
    train(32'hA10, 32'h0, 1'b1, br_return);
    train(32'h908, 32'h0, 1'b1, br_return);
    pulse_redirect(32'h7F8);
    // Innermost four unwind in order
    expect_return(32'hD24, 32'hC20);
    expect_return(32'hC20, 32'hB18);
    expect_return(32'hB18, 32'hA10);
    expect_return(32'hA10, 32'h908);
    probe_ras = 1'b0;
    // Outermost return finds the stack empty and falls through
    wait_fire_at(32'h90C);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the fetch stream stopped making progress", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(71858));
    arst_n         = 1'b0;
    out_ready      = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    upd_valid      = 1'b0;
    upd_pc         = '0;
    upd_tgt        = '0;
    upd_taken      = 1'b0;
    upd_kind       = br_jump;
    probe_pc       = '0;
    probe_btb      = 1'b0;
    probe_taken    = 1'b0;
    probe_tgt      = '0;
    probe_kind     = br_jump;
    probe_ras      = 1'b0;
    probe_ras_tgt  = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    out_ready <= 1'b1;
    wait_fires(24);
    close_test("reset_and_stream");
    random_backpressure();
    close_test("backpressure");
    redirect_flush();
    close_test("redirect_flush");
    btb_jump();
    close_test("btb_jump");
    call_return();
    close_test("call_return");
    nested_calls();
    close_test("nested_calls");
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d cycles",
             tests_run, tests_failed, err_count, cycles);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: files.f
fetch_pkg.sv
fetch_pred_if.sv
fetch_pc_gen.sv
fetch_btb.sv
fetch_ras.sv
fetch_stage_sram.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - fetch_pred_if.sv
  - fetch_pc_gen.sv
  - fetch_btb.sv
  - fetch_ras.sv
  - fetch_stage_sram.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv
